/* aluOperandIf.sv */
////////////////////////////////////////
// Operand bus from the select muxes to the function units
// Purely combinational, no handshake
////////////////////////////////////////

`timescale 1ns/1ps

interface aluOperandIf;

    import aluPkg::*;

    // Adder and shifter left operand
    data_t q;
    // Right operand shared by logic unit and adder
    data_t r;
    // Logic unit left operand
    data_t l;
    // Carry into adder and shifter
    logic  ci;
    // Operation code, bit 0 doubles as direction and subtract select
    luOp_e op;

    modport source (
        output q,
        output r,
        output l,
        output ci,
        output op
    );

    modport sink (
        input q,
        input r,
        input l,
        input ci,
        input op
    );

endinterface

/* aluPkg.sv */
////////////////////////////////////////
// Shared widths, types and control codes of the 6502 execution ALU
// Modules import this for their field types and select encodings
////////////////////////////////////////

package aluPkg;

    // Byte-wide data path throughout
    localparam int DataWidth   = 8;
    // Operand and carry select fields are all two bits wide
    localparam int SelWidth    = 2;
    localparam int RegSelWidth = 3;
    localparam int CcSelWidth  = 4;
    localparam int FuWidth     = 4;

    typedef logic [DataWidth-1:0] data_t;

    // One-hot unit select, transfer in the top bit and add in the bottom bit
    typedef logic [FuWidth-1:0] fuSel_t;

    // Bit positions inside fuSel_t
    typedef enum logic [1:0] {
        FuAdd   = 2'd0,
        FuShift = 2'd1,
        FuLogic = 2'd2,
        FuXfr   = 2'd3
    } fuBit_e;

    // Logic unit operation; bit 0 also picks shift direction and adder subtract
    typedef enum logic [SelWidth-1:0] {
        LuClr = 2'd0,
        LuAnd = 2'd1,
        LuOr  = 2'd2,
        LuXor = 2'd3
    } luOp_e;

    // Names follow the adder/shifter table; the logic left operand reads M, K, P, A
    typedef enum logic [SelWidth-1:0] {
        QSelM = 2'd0,
        QSelX = 2'd1,
        QSelY = 2'd2,
        QSelA = 2'd3
    } qSel_e;

    typedef enum logic [SelWidth-1:0] {
        RSelM = 2'd0,
        RSelK = 2'd1,
        RSelP = 2'd2,
        RSelA = 2'd3
    } rSel_e;

    typedef enum logic [SelWidth-1:0] {
        CSelC    = 2'd0,
        CSelZero = 2'd1,
        CSelOne  = 2'd2,
        CSelQ7   = 2'd3
    } cSel_e;

    // Destination and output source; RegNone outputs zero and RegTmp writes nothing
    typedef enum logic [RegSelWidth-1:0] {
        RegNone = 3'd0,
        RegX    = 3'd1,
        RegY    = 3'd2,
        RegA    = 3'd3,
        RegTmp  = 3'd4,
        RegS    = 3'd5,
        RegP    = 3'd6,
        RegM    = 3'd7
    } regSel_e;

    // Low three bits pick the flag update, high bit turns the code into a branch test
    typedef enum logic [CcSelWidth-1:0] {
        CcPsw  = 4'd0,
        CcKeep1 = 4'd1,
        CcZ    = 4'd2,
        CcNVZ  = 4'd3,
        CcKeep4 = 4'd4,
        CcNZ   = 4'd5,
        CcNZC  = 4'd6,
        CcNVZC = 4'd7,
        CcBrCC = 4'd8,
        CcBrCS = 4'd9,
        CcBrNE = 4'd10,
        CcBrEQ = 4'd11,
        CcBrVC = 4'd12,
        CcBrVS = 4'd13,
        CcBrPL = 4'd14,
        CcBrMI = 4'd15
    } ccSel_e;

    // Flag positions in P, bit 5 is unnamed and always reads 1
    typedef enum logic [2:0] {
        PswC = 3'd0,
        PswZ = 3'd1,
        PswI = 3'd2,
        PswD = 3'd3,
        PswB = 3'd4,
        PswV = 3'd6,
        PswN = 3'd7
    } pswBit_e;

    // Bits 5 and 4 set, interrupts masked
    localparam data_t PswReset = 8'h34;

endpackage

/* aluModel.svh */
////////////////////////////////////////
// Reference model of the execution ALU for the testbench
// Included inside the testbench module, it mirrors A, X, Y, P and CCOut
////////////////////////////////////////

`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Architectural state as the model sees it after the last edge
data_t mA;
data_t mX;
data_t mY;
data_t mP;
logic  mCC;

// Values of the current cycle, valid between evalModel and advanceModel
data_t expDo;
logic  expVal;
logic  expCarry;
logic  expOvf;
logic  expAndZero;

task automatic resetModel();
    mA  = '0;
    mX  = '0;
    mY  = '0;
    // Bits 5 and 4 always read one, I is set out of reset
    mP  = 8'h34;
    mCC = 1'b1;
endtask

// Works out the result bus and unit flags from the inputs and model state
task automatic evalModel();
    data_t q;
    data_t l;
    data_t r;
    data_t rAdd;
    data_t xfrVal;
    data_t luVal;
    data_t shVal;
    logic  ci;
    logic  shOut;
    int    sumU;
    int    sumS;
    int    qS;
    int    rS;

    // Shift and add read M, X, Y, A on Q
    case (QSel)
        QSelM: q = M;
        QSelX: q = mX;
        QSelY: q = mY;
        default: q = mA;
    endcase
    // The logic unit reads M, K, P, A on the same select
    case (QSel)
        QSelM: l = M;
        QSelX: l = K;
        QSelY: l = mP;
        default: l = mA;
    endcase
    case (RSel)
        RSelM: r = M;
        RSelK: r = K;
        RSelP: r = mP;
        default: r = mA;
    endcase
    case (CSel)
        CSelC: ci = mP[0];
        CSelZero: ci = 1'b0;
        CSelOne: ci = 1'b1;
        default: ci = q[7];
    endcase
    case (OSel)
        RegX: xfrVal = mX;
        RegY: xfrVal = mY;
        RegA: xfrVal = mA;
        RegS: xfrVal = S;
        RegP: xfrVal = mP;
        RegM: xfrVal = M;
        default: xfrVal = 8'h00;
    endcase
    case (Op)
        LuClr: luVal = ~l & r;
        LuAnd: luVal = l & r;
        LuOr: luVal = l | r;
        default: luVal = l ^ r;
    endcase

    // Op bit 0 set means a right shift
    shVal = Op[0] ? {ci, q[7:1]} : {q[6:0], ci};
    shOut = Op[0] ? q[0] : q[7];

    // Adder in plain integers, subtraction adds the complement of R
    rAdd = Op[0] ? ~r : r;
    sumU = int'(q) + int'(rAdd) + int'(ci);
    qS   = q[7] ? int'(q) - 256 : int'(q);
    rS   = rAdd[7] ? int'(rAdd) - 256 : int'(rAdd);
    sumS = qS + rS + int'(ci);

    expDo = 8'h00;
    if (En && fuSel[3])
        expDo = expDo | xfrVal;
    if (En && fuSel[2])
        expDo = expDo | luVal;
    if (En && fuSel[1])
        expDo = expDo | shVal;
    if (En && fuSel[0])
        expDo = expDo | sumU[7:0];

    expCarry   = (En & fuSel[1] & shOut) | (En & fuSel[0] & (sumU > 255));
    expOvf     = En & fuSel[0] & ((sumS > 127) || (sumS < -128));
    expAndZero = ((l & r) == 8'h00);
    expVal     = (fuSel == 4'b0000) || (En && (fuSel != 4'b0000));
endtask

// Applies one rising edge to the model state
task automatic advanceModel();
    logic eq;
    logic newCC;

    // EQ and NE look at the masked AND while the logic unit runs
    eq = (En & fuSel[2]) ? expAndZero : mP[1];
    newCC = 1'b1;
    if (CCSel[3])
    begin
        case (CCSel[2:0])
            3'd0: newCC = ~mP[0];
            3'd1: newCC = mP[0];
            3'd2: newCC = ~eq;
            3'd3: newCC = eq;
            3'd4: newCC = ~mP[6];
            3'd5: newCC = mP[6];
            3'd6: newCC = ~mP[7];
            default: newCC = mP[7];
        endcase
    end

    if (expVal && Rdy)
    begin
        if (WSel == RegA)
            mA = expDo;
        if (WSel == RegX)
            mX = expDo;
        if (WSel == RegY)
            mY = expDo;
        case (CCSel[2:0])
            3'd0:
            begin
                if (WSel == RegP)
                    mP = expDo | 8'h30;
            end
            3'd2: mP[1] = expAndZero;
            3'd3:
            begin
                mP[7] = M[7];
                mP[6] = M[6];
                mP[1] = expAndZero;
            end
            3'd5:
            begin
                mP[7] = expDo[7];
                mP[1] = (expDo == 8'h00);
            end
            3'd6:
            begin
                mP[7] = expDo[7];
                mP[1] = (expDo == 8'h00);
                mP[0] = expCarry;
            end
            3'd7:
            begin
                mP[7] = expDo[7];
                mP[6] = expOvf;
                mP[1] = (expDo == 8'h00);
                mP[0] = expCarry;
            end
            default: ;
        endcase
    end

    // CCOut holds while Rdy is low
    if (Rdy)
        mCC = newCC;
endtask

`endif

/* aluTb.sv */
////////////////////////////////////////
// Testbench for the execution ALU top level
// Random cycles per test are checked against the included model
////////////////////////////////////////

`timescale 1ns/1ps

module aluTb;

    import aluPkg::*;

    localparam int TestLength  = 200;
    localparam int ResetCycles = 10;
    // Reset and five tests of TestLength cycles, with a margin
    localparam int CycleLimit  = ResetCycles + 5 * TestLength + 390;

    logic    Clk;
    logic    rst;
    logic    Rdy;
    logic    En;
    fuSel_t  fuSel;
    luOp_e   Op;
    qSel_e   QSel;
    rSel_e   RSel;
    cSel_e   CSel;
    regSel_e WSel;
    regSel_e OSel;
    ccSel_e  CCSel;
    data_t   K;
    data_t   M;
    data_t   S;
    data_t   DO;
    logic    Val;
    logic    CCOut;
    logic    SelS;
    data_t   A;
    data_t   X;
    data_t   Y;
    data_t   P;

    int seed;
    int cycleCount = 0;
    int testErrors = 0;
    int totalErrors = 0;
    int failedTests = 0;
    int checkCount = 0;

    `include "aluModel.svh"

    aluTop UUT (
        .Clk(Clk), .rst(rst), .Rdy(Rdy), .En(En), .fuSel(fuSel), .Op(Op),
        .QSel(QSel), .RSel(RSel), .CSel(CSel), .WSel(WSel), .OSel(OSel),
        .CCSel(CCSel), .K(K), .M(M), .S(S), .DO(DO), .Val(Val), .CCOut(CCOut),
        .SelS(SelS), .A(A), .X(X), .Y(Y), .P(P)
    );

    initial
    begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // Guard against a stalled run
    initial
    begin
        while (cycleCount < CycleLimit)
        begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        nextRand = $random(seed);
    endfunction

    task automatic compareValue(input string what, input data_t got, input data_t exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            testErrors++;
            $display("** Error at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    // Outputs are stable here, half a cycle after the inputs moved
    task automatic checkOutputs();
        compareValue("DO", DO, expDo);
        compareValue("Val", 8'(Val), 8'(expVal));
        compareValue("SelS", 8'(SelS), 8'(WSel == RegS));
        compareValue("A", A, mA);
        compareValue("X", X, mX);
        compareValue("Y", Y, mY);
        compareValue("P", P, mP);
        compareValue("CCOut", 8'(CCOut), 8'(mCC));
    endtask

    // All fields random, then narrowed to what the test exercises
    task automatic driveFields(input int testId);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;

        r1 = nextRand();
        r2 = nextRand();
        r3 = nextRand();
        En    <= 1'b1;
        Rdy   <= (r1[1:0] != 2'b00);
        Op    <= luOp_e'(r1[5:4]);
        QSel  <= qSel_e'(r1[7:6]);
        RSel  <= rSel_e'(r1[9:8]);
        CSel  <= cSel_e'(r1[11:10]);
        WSel  <= regSel_e'(r1[14:12]);
        OSel  <= regSel_e'(r1[17:15]);
        CCSel <= ccSel_e'(r1[21:18]);
        K     <= r2[7:0];
        M     <= r2[15:8];
        S     <= r2[23:16];
        case (testId)
            2:
            begin
                fuSel <= 4'b1000;
                En    <= r3[0] | r3[1];
            end
            3:
            begin
                fuSel <= 4'b0100;
                CCSel <= r3[1] ? (r3[0] ? CcNZ : CcNVZ) : (r3[0] ? CcZ : CcPsw);
            end
            4:
            begin
                fuSel <= 4'b0010;
                CCSel <= CcNZC;
            end
            5:
            begin
                // PSW loads now and then scatter the D flag
                fuSel <= 4'b0001;
                CCSel <= (r3[1:0] == 2'b00) ? CcPsw : (r3[2] ? CcNVZC : CcNZC);
            end
            default:
            begin
                fuSel <= r3[3:0];
                En    <= r3[4] | r3[5];
                CCSel <= ccSel_e'({r3[6] | r3[7], r1[20:18]});
            end
        endcase
    endtask

    task automatic reportTest(input int testId, input string name);
        if (testErrors == 0)
            $display("Test %0d (%s): passed", testId, name);
        else
        begin
            failedTests++;
            $display("Test %0d (%s): failed with %0d errors", testId, name, testErrors);
        end
        totalErrors += testErrors;
        testErrors = 0;
    endtask

    task automatic runTest(input int testId, input string name);
        repeat (TestLength)
        begin
            @(posedge Clk);
            driveFields(testId);
            @(negedge Clk);
            evalModel();
            checkOutputs();
            advanceModel();
        end
        reportTest(testId, name);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        seed  = 96323;
        rst   = 1'b1;
        Rdy   = 1'b0;
        En    = 1'b0;
        fuSel = 4'b0000;
        Op    = LuClr;
        QSel  = QSelM;
        RSel  = RSelM;
        CSel  = CSelC;
        WSel  = RegNone;
        OSel  = RegNone;
        CCSel = CcPsw;
        K     = 8'h00;
        M     = 8'h00;
        S     = 8'h00;
        resetModel();

        repeat (ResetCycles) @(posedge Clk);
        rst <= 1'b0;
        @(negedge Clk);
        // Rdy is still low, so the first edge after reset changes nothing
        evalModel();
        checkOutputs();
        advanceModel();
        reportTest(1, "reset");

        runTest(2, "transfer and writes");
        runTest(3, "logic unit");
        runTest(4, "shifts");
        runTest(5, "adder");
        runTest(6, "branch condition");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 6, failedTests, checkCount, totalErrors);
        if (totalErrors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* aluTop.sv */
////////////////////////////////////////
// Top level of the execution ALU, plain ports toward the core
// Control fields come from the decoder and microprogram ROMs
////////////////////////////////////////

`timescale 1ns/1ps

module aluTop (
    input  logic            Clk,
    input  logic            rst,
    input  logic            Rdy,
    input  logic            En,
    input  aluPkg::fuSel_t  fuSel,
    input  aluPkg::luOp_e   Op,
    input  aluPkg::qSel_e   QSel,
    input  aluPkg::rSel_e   RSel,
    input  aluPkg::cSel_e   CSel,
    input  aluPkg::regSel_e WSel,
    input  aluPkg::regSel_e OSel,
    input  aluPkg::ccSel_e  CCSel,
    input  aluPkg::data_t   K,
    input  aluPkg::data_t   M,
    input  aluPkg::data_t   S,
    output aluPkg::data_t   DO,
    output logic            Val,
    output logic            CCOut,
    output logic            SelS,
    output aluPkg::data_t   A,
    output aluPkg::data_t   X,
    output aluPkg::data_t   Y,
    output aluPkg::data_t   P
);

    import aluPkg::*;

    // Unit enables from the one-hot select
    wire luEn    = En & fuSel[FuLogic];
    wire shiftEn = En & fuSel[FuShift];
    wire addEn   = En & fuSel[FuAdd];

    data_t luResult;
    data_t asResult;
    logic  luZero;
    logic  carryOut;
    logic  overflow;
    logic  selP;

    aluOperandIf opndBus ();

    operandSelect operandMux (
        .QSel(QSel), .RSel(RSel), .CSel(CSel), .Op(Op),
        .M(M), .K(K), .A(A), .X(X), .Y(Y), .P(P),
        .opnd(opndBus.source)
    );

    logicUnit logicU (
        .En(luEn), .opnd(opndBus.sink), .result(luResult), .luZero(luZero)
    );

    arithShiftUnit arithU (
        .shiftEn(shiftEn), .addEn(addEn), .opnd(opndBus.sink),
        .result(asResult), .carryOut(carryOut), .overflow(overflow)
    );

    // DO is the combined result bus itself
    registerBank regs (
        .Clk(Clk), .rst(rst), .Rdy(Rdy), .En(En), .fuSel(fuSel),
        .WSel(WSel), .OSel(OSel), .luResult(luResult), .asResult(asResult),
        .M(M), .S(S), .P(P), .aluResult(DO), .Val(Val), .SelS(SelS),
        .selP(selP), .A(A), .X(X), .Y(Y)
    );

    statusRegister psw (
        .Clk(Clk), .rst(rst), .Rdy(Rdy), .Val(Val), .selP(selP), .luEn(luEn),
        .CCSel(CCSel), .aluResult(DO), .M(M), .carryOut(carryOut),
        .overflow(overflow), .luZero(luZero), .P(P), .CCOut(CCOut)
    );

endmodule

/* arithShiftUnit.sv */
////////////////////////////////////////
// Shift/rotate unit and binary adder
// Both share Q and the carry in, results are OR'ed under their enables
////////////////////////////////////////

`timescale 1ns/1ps

module arithShiftUnit (
    input  logic          shiftEn,
    input  logic          addEn,
    aluOperandIf.sink     opnd,
    output aluPkg::data_t result,
    output logic          carryOut,
    output logic          overflow
);

    import aluPkg::*;

    ////////////////////////////////////////
    // Shifter
    ////////////////////////////////////////

    data_t shiftValue;
    logic  shiftCarry;

    // Op bit 0 clear shifts left, set shifts right
    // ROL/ROR against ASL/LSR is only a matter of the carry select
    always_comb
    begin
        if (opnd.op[0])
        begin
            shiftValue = {opnd.ci, opnd.q[DataWidth-1:1]};
            shiftCarry = opnd.q[0];
        end
        else
        begin
            shiftValue = {opnd.q[DataWidth-2:0], opnd.ci};
            shiftCarry = opnd.q[DataWidth-1];
        end
    end

    ////////////////////////////////////////
    // Adder
    ////////////////////////////////////////

    data_t                rOperand;
    logic  [DataWidth:0]  sum;
    logic                 addOverflow;

    // Subtraction by one's complement of R, the carry in supplies the +1
    assign rOperand = opnd.op[0] ? ~opnd.r : opnd.r;

    assign sum = {1'b0, opnd.q} + {1'b0, rOperand} + (DataWidth+1)'(opnd.ci);

    // Signed overflow when both inputs agree in sign and the sum does not
    assign addOverflow = (opnd.q[DataWidth-1] == rOperand[DataWidth-1])
                       & (sum[DataWidth-1] != opnd.q[DataWidth-1]);

    ////////////////////////////////////////
    // Gated outputs
    ////////////////////////////////////////

    assign result = (shiftEn ? shiftValue : '0) | (addEn ? sum[DataWidth-1:0] : '0);

    // Carry from whichever unit is on, zero when neither is
    assign carryOut = (shiftEn & shiftCarry) | (addEn & sum[DataWidth]);

    // Shifts never flag overflow
    assign overflow = addEn & addOverflow;

endmodule

/* logicUnit.sv */
////////////////////////////////////////
// Bit-wise logic unit with masked zero detect
// Serves AND/ORA/EOR, BIT, TRB/TSB, RMB/SMB and the flag set/clear ops
////////////////////////////////////////

`timescale 1ns/1ps

module logicUnit (
    input  logic          En,
    aluOperandIf.sink     opnd,
    output aluPkg::data_t result,
    output logic          luZero
);

    import aluPkg::*;

    data_t luValue;

    // CLR gives ~L & R, which clears the bits of R that the mask in L selects
    always_comb
    begin
        case (opnd.op)
            LuClr: luValue = ~opnd.l & opnd.r;
            LuAnd: luValue = opnd.l & opnd.r;
            LuOr: luValue = opnd.l | opnd.r;
            default: luValue = opnd.l ^ opnd.r;
        endcase
    end

    // Disabled unit contributes zero to the OR'ed result bus
    assign result = En ? luValue : '0;

    // Zero test of L and R for BIT, TRB/TSB and the bit branches
    // It ignores the operation so TRB still reports the tested bits
    assign luZero = ~|(opnd.l & opnd.r);

endmodule

/* operandSelect.sv */
////////////////////////////////////////
// Operand multiplexers for the logic, shift and add units
// One Q select drives two left operand muxes with different tables
////////////////////////////////////////

`timescale 1ns/1ps

module operandSelect (
    input  aluPkg::qSel_e QSel,
    input  aluPkg::rSel_e RSel,
    input  aluPkg::cSel_e CSel,
    input  aluPkg::luOp_e Op,
    input  aluPkg::data_t M,
    input  aluPkg::data_t K,
    input  aluPkg::data_t A,
    input  aluPkg::data_t X,
    input  aluPkg::data_t Y,
    input  aluPkg::data_t P,
    aluOperandIf.source   opnd
);

    import aluPkg::*;

    // Operation code passes straight to the units
    assign opnd.op = Op;

    // Logic left operand uses the M, K, P, A table
    always_comb
    begin
        case (QSel)
            QSelM: opnd.l = M;
            QSelX: opnd.l = K;
            QSelY: opnd.l = P;
            default: opnd.l = A;
        endcase
    end

    // Adder and shifter left operand uses the M, X, Y, A table
    always_comb
    begin
        case (QSel)
            QSelM: opnd.q = M;
            QSelX: opnd.q = X;
            QSelY: opnd.q = Y;
            default: opnd.q = A;
        endcase
    end

    // K on the right lets INC/DEC step by any amount and masks reach memory or P
    always_comb
    begin
        case (RSel)
            RSelM: opnd.r = M;
            RSelK: opnd.r = K;
            RSelP: opnd.r = P;
            default: opnd.r = A;
        endcase
    end

    // Carry in, Q bit 7 gives an arithmetic right shift
    always_comb
    begin
        case (CSel)
            CSelC: opnd.ci = P[PswC];
            CSelZero: opnd.ci = 1'b0;
            CSelOne: opnd.ci = 1'b1;
            default: opnd.ci = opnd.q[DataWidth-1];
        endcase
    end

endmodule

/* project.f */
+incdir+.
aluPkg.sv
aluOperandIf.sv
operandSelect.sv
logicUnit.sv
arithShiftUnit.sv
registerBank.sv
statusRegister.sv
aluTop.sv
aluTb.sv

/* registerBank.sv */
////////////////////////////////////////
// Result bus, transfer mux, write decode and the A, X, Y registers
// Registers load from the result bus when Val and Rdy are both high
////////////////////////////////////////

`timescale 1ns/1ps

module registerBank (
    input  logic            Clk,
    input  logic            rst,
    input  logic            Rdy,
    input  logic            En,
    input  aluPkg::fuSel_t  fuSel,
    input  aluPkg::regSel_e WSel,
    input  aluPkg::regSel_e OSel,
    input  aluPkg::data_t   luResult,
    input  aluPkg::data_t   asResult,
    input  aluPkg::data_t   M,
    input  aluPkg::data_t   S,
    input  aluPkg::data_t   P,
    output aluPkg::data_t   aluResult,
    output logic            Val,
    output logic            SelS,
    output logic            selP,
    output aluPkg::data_t   A,
    output aluPkg::data_t   X,
    output aluPkg::data_t   Y
);

    import aluPkg::*;

    logic  xfrEn;
    data_t xfrValue;
    logic  selA;
    logic  selX;
    logic  selY;
    logic  writeEn;

    ////////////////////////////////////////
    // Load/store/transfer mux
    ////////////////////////////////////////

    assign xfrEn = En & fuSel[FuXfr];

    // Code 0 stores zero (STZ), code 4 has no source and also reads zero
    always_comb
    begin
        case (OSel)
            RegX: xfrValue = X;
            RegY: xfrValue = Y;
            RegA: xfrValue = A;
            RegS: xfrValue = S;
            RegP: xfrValue = P;
            RegM: xfrValue = M;
            default: xfrValue = '0;
        endcase
    end

    // Only one unit is enabled at a time, the others give zero
    assign aluResult = (xfrEn ? xfrValue : '0) | luResult | asResult;

    // No unit selected is a NOP and counts as valid at once
    assign Val = ~|fuSel | (En & |fuSel);

    ////////////////////////////////////////
    // Destination decode
    ////////////////////////////////////////

    assign selX = (WSel == RegX);
    assign selY = (WSel == RegY);
    assign selA = (WSel == RegA);
    // S lives in the address generator, which does its own write
    assign SelS = (WSel == RegS);
    assign selP = (WSel == RegP);

    assign writeEn = Val & Rdy;

    ////////////////////////////////////////
    // A, X and Y
    ////////////////////////////////////////

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            A <= '0;
            X <= '0;
            Y <= '0;
        end
        else if (writeEn)
        begin
            if (selA)
                A <= aluResult;
            if (selX)
                X <= aluResult;
            if (selY)
                Y <= aluResult;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Compiles the ALU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aluTb -f project.f -o aluSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/aluSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1

/* statusRegister.sv */
////////////////////////////////////////
// Processor status P with the condition-code update rules
// Also registers the branch condition test into CCOut
////////////////////////////////////////

`timescale 1ns/1ps

module statusRegister (
    input  logic           Clk,
    input  logic           rst,
    input  logic           Rdy,
    input  logic           Val,
    input  logic           selP,
    input  logic           luEn,
    input  aluPkg::ccSel_e CCSel,
    input  aluPkg::data_t  aluResult,
    input  aluPkg::data_t  M,
    input  logic           carryOut,
    input  logic           overflow,
    input  logic           luZero,
    output aluPkg::data_t  P,
    output logic           CCOut
);

    import aluPkg::*;

    logic   nFlag;
    logic   vFlag;
    logic   dFlag;
    logic   iFlag;
    logic   zFlag;
    logic   cFlag;
    ccSel_e update;
    logic   equal;

    // Branch codes carry the same low-bit update as the plain codes
    assign update = ccSel_e'({1'b0, CCSel[2:0]});

    ////////////////////////////////////////
    // Flag registers
    ////////////////////////////////////////

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            nFlag <= PswReset[PswN];
            vFlag <= PswReset[PswV];
            dFlag <= PswReset[PswD];
            iFlag <= PswReset[PswI];
            zFlag <= PswReset[PswZ];
            cFlag <= PswReset[PswC];
        end
        else if (Val & Rdy)
        begin
            case (update)
                // PLP and the flag set/clear ops write P as a whole
                CcPsw:
                begin
                    if (selP)
                    begin
                        nFlag <= aluResult[PswN];
                        vFlag <= aluResult[PswV];
                        dFlag <= aluResult[PswD];
                        iFlag <= aluResult[PswI];
                        zFlag <= aluResult[PswZ];
                        cFlag <= aluResult[PswC];
                    end
                end
                // BIT #imm, TRB and TSB
                CcZ: zFlag <= luZero;
                // BIT on memory copies the top two operand bits
                CcNVZ:
                begin
                    nFlag <= M[7];
                    vFlag <= M[6];
                    zFlag <= luZero;
                end
                CcNZ:
                begin
                    nFlag <= aluResult[DataWidth-1];
                    zFlag <= ~|aluResult;
                end
                CcNZC:
                begin
                    nFlag <= aluResult[DataWidth-1];
                    zFlag <= ~|aluResult;
                    cFlag <= carryOut;
                end
                CcNVZC:
                begin
                    nFlag <= aluResult[DataWidth-1];
                    vFlag <= overflow;
                    zFlag <= ~|aluResult;
                    cFlag <= carryOut;
                end
                default: ;
            endcase
        end
    end

    // B and bit 5 have no storage and read as one
    always_comb
    begin
        P       = '1;
        P[PswN] = nFlag;
        P[PswV] = vFlag;
        P[PswB] = 1'b1;
        P[PswD] = dFlag;
        P[PswI] = iFlag;
        P[PswZ] = zFlag;
        P[PswC] = cFlag;
    end

    ////////////////////////////////////////
    // Branch condition
    ////////////////////////////////////////

    // BBR/BBS test the masked bit directly while the logic unit runs
    assign equal = luEn ? luZero : zFlag;

    always_ff @(posedge Clk)
    begin
        if (rst)
            CCOut <= 1'b1;
        else if (Rdy)
        begin
            case (CCSel)
                CcBrCC: CCOut <= ~cFlag;
                CcBrCS: CCOut <= cFlag;
                CcBrNE: CCOut <= ~equal;
                CcBrEQ: CCOut <= equal;
                CcBrVC: CCOut <= ~vFlag;
                CcBrVS: CCOut <= vFlag;
                CcBrPL: CCOut <= ~nFlag;
                CcBrMI: CCOut <= nFlag;
                default: CCOut <= 1'b1;
            endcase
        end
    end

endmodule
